//--- rat_geom_pkg.sv
// Register alias table geometry
// Table size, field widths and port counts shared by the RAT blocks

package rat_geom_pkg;

  // architectural registers tracked by the table
  localparam int NUM_ARCH = 32;
  localparam int ARCH_W   = 5;

  // reorder buffer tag and functional-unit one-hot widths
  localparam int ROB_W = 9;
  localparam int FUN_W = 10;

  // port counts
  localparam int NUM_RD  = 4;
  localparam int NUM_WR  = 3;
  localparam int NUM_RET = 3;

  // only the top functional-unit bit is set after reset
  localparam logic [FUN_W-1:0] FUN_RESET = {1'b1, {(FUN_W-1){1'b0}}};

endpackage

//--- rat_types_pkg.sv
// Register alias table types
// Port bundles, the visible entry state and the register domain encoding

package rat_types_pkg;

  typedef enum logic [1:0] {
    DOM_INT    = 2'd0,
    DOM_SCALAR = 2'd1,
    DOM_DOUBLE = 2'd2,
    DOM_VECTOR = 2'd3
  } reg_dom_e;

  // with dep set, reg_idx numbers a rename slot of the current group
  typedef struct packed {
    logic                             dep;
    logic [rat_geom_pkg::ARCH_W-1:0]  reg_idx;
  } rat_rd_addr_t;

  typedef struct packed {
    logic                             wen;
    logic [rat_geom_pkg::ARCH_W-1:0]  arch;
    logic [rat_geom_pkg::ROB_W-1:0]   tag;
    logic [rat_geom_pkg::FUN_W-1:0]   fun;
    reg_dom_e                         dom;
  } rat_wr_t;

  typedef struct packed {
    logic                             wen;
    logic [rat_geom_pkg::ROB_W-1:0]   tag;
    logic [rat_geom_pkg::ARCH_W-1:0]  arch;
    reg_dom_e                         dom;
  } rat_ret_t;

  typedef struct packed {
    logic [rat_geom_pkg::ROB_W-1:0]   tag;
    logic                             retired;
    logic [rat_geom_pkg::FUN_W-1:0]   fun;
    reg_dom_e                         dom;
  } rat_entry_t;

  typedef struct packed {
    logic [rat_geom_pkg::ROB_W-1:0]   tag;
    logic                             retired;
    logic                             is_dep;
    logic [rat_geom_pkg::FUN_W-1:0]   fun;
    reg_dom_e                         dom;
  } rat_rd_rsp_t;

endpackage

//--- rat_entry.sv
// Register alias table entry
// Holds the newest writer tag, retired flag, functional unit and domain of
// one architectural register, plus the domain pending for retire-all

module rat_entry #(
  parameter int INDEX = 0
) (
  input  logic                                             clk,
  input  logic                                             rst,
  input  logic                                             read_en,
  input  rat_types_pkg::rat_wr_t  [rat_geom_pkg::NUM_WR-1:0]  wr,
  input  rat_types_pkg::rat_ret_t [rat_geom_pkg::NUM_RET-1:0] ret,
  input  logic                                             retire_all,
  output rat_types_pkg::rat_entry_t                        entry
);

  logic [rat_geom_pkg::ROB_W-1:0] tag_q;
  logic                           retired_q;
  logic [rat_geom_pkg::FUN_W-1:0] fun_q;
  rat_types_pkg::reg_dom_e        dom_q;
  rat_types_pkg::reg_dom_e        pend_q;

  logic                           ren_hit;
  logic [rat_geom_pkg::ROB_W-1:0] ren_tag;
  logic [rat_geom_pkg::FUN_W-1:0] ren_fun;
  rat_types_pkg::reg_dom_e        ren_dom;
  logic                           tag_hit;
  logic                           pend_hit;
  rat_types_pkg::reg_dom_e        pend_dom;

  // later rename ports override earlier ones
  always_comb
  begin
    ren_hit = 1'b0;
    ren_tag = '0;
    ren_fun = '0;
    ren_dom = rat_types_pkg::DOM_INT;
    for (int i = 0; i < rat_geom_pkg::NUM_WR; i++)
    begin
      if (read_en && wr[i].wen && int'(wr[i].arch) == INDEX)
      begin
        ren_hit = 1'b1;
        ren_tag = wr[i].tag;
        ren_fun = wr[i].fun;
        ren_dom = wr[i].dom;
      end
    end
  end

  // tag match against the stored writer, and
  // arch match for the pending domain
  always_comb
  begin
    tag_hit  = 1'b0;
    pend_hit = 1'b0;
    pend_dom = rat_types_pkg::DOM_INT;
    for (int i = 0; i < rat_geom_pkg::NUM_RET; i++)
    begin
      if (ret[i].wen && ret[i].tag == tag_q)
        tag_hit = 1'b1;
      if (ret[i].wen && int'(ret[i].arch) == INDEX)
      begin
        pend_hit = 1'b1;
        pend_dom = ret[i].dom;
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      tag_q     <= '0;
      retired_q <= 1'b1;
      fun_q     <= rat_geom_pkg::FUN_RESET;
      dom_q     <= rat_types_pkg::DOM_INT;
      pend_q    <= rat_types_pkg::DOM_INT;
    end
    else
    begin
      if (ren_hit)
      begin
        tag_q <= ren_tag;
        fun_q <= ren_fun;
      end
      // retire-all wins over a rename for retired and dom
      if (retire_all)
      begin
        retired_q <= 1'b1;
        dom_q     <= pend_q;
      end
      else if (ren_hit)
      begin
        retired_q <= 1'b0;
        dom_q     <= ren_dom;
      end
      else if (tag_hit)
        retired_q <= 1'b1;
      if (pend_hit)
        pend_q <= pend_dom;
    end
  end

  assign entry = '{tag: tag_q, retired: retired_q, fun: fun_q, dom: dom_q};

endmodule

//--- rat_table.sv
// Register alias table storage
// One entry per architectural register; every rename and retirement port
// is broadcast to all entries, which match on their own index

module rat_table (
  input  logic                                                  clk,
  input  logic                                                  rst,
  input  logic                                                  read_en,
  input  rat_types_pkg::rat_wr_t     [rat_geom_pkg::NUM_WR-1:0]   wr,
  input  rat_types_pkg::rat_ret_t    [rat_geom_pkg::NUM_RET-1:0]  ret,
  input  logic                                                  retire_all,
  output rat_types_pkg::rat_entry_t  [rat_geom_pkg::NUM_ARCH-1:0] entries
);

  genvar g;

  generate
    for (g = 0; g < rat_geom_pkg::NUM_ARCH; g++)
    begin : g_entry
      rat_entry #(
        .INDEX (g)
      ) u_entry (
        .clk        (clk),
        .rst        (rst),
        .read_en    (read_en),
        .wr         (wr),
        .ret        (ret),
        .retire_all (retire_all),
        .entry      (entries[g])
      );
    end
  endgenerate

endmodule

//--- rat_read_port.sv
// Register alias table read port
// Registers the read address under read_en, then returns either the
// addressed entry or, for a dep address, the rename slot of this cycle

module rat_read_port (
  input  logic                                                  clk,
  input  logic                                                  rst,
  input  logic                                                  read_en,
  input  rat_types_pkg::rat_rd_addr_t                           rd_addr,
  input  rat_types_pkg::rat_entry_t  [rat_geom_pkg::NUM_ARCH-1:0] entries,
  input  rat_types_pkg::rat_wr_t     [rat_geom_pkg::NUM_WR-1:0]   wr,
  output rat_types_pkg::rat_rd_rsp_t                            rd_rsp
);

  rat_types_pkg::rat_rd_addr_t addr_q;

  always_ff @(posedge clk)
  begin
    if (rst)
      addr_q <= '0;
    else if (read_en)
      addr_q <= rd_addr;
  end

  always_comb
  begin
    rd_rsp = '0;
    if (addr_q.dep)
    begin
      // slots past NUM_WR leave the bypass fields at zero
      rd_rsp.is_dep = 1'b1;
      for (int i = 0; i < rat_geom_pkg::NUM_WR; i++)
      begin
        if (int'(addr_q.reg_idx) == i)
        begin
          rd_rsp.tag = wr[i].tag;
          rd_rsp.fun = wr[i].fun;
          rd_rsp.dom = wr[i].dom;
        end
      end
    end
    else
    begin
      rd_rsp.tag     = entries[addr_q.reg_idx].tag;
      rd_rsp.retired = entries[addr_q.reg_idx].retired;
      rd_rsp.fun     = entries[addr_q.reg_idx].fun;
      rd_rsp.dom     = entries[addr_q.reg_idx].dom;
    end
  end

endmodule

//--- rat_top.sv
// Vector register alias table
// 32-entry rename map with four read ports, three rename ports, three
// retirement ports and a global retire-all

module rat_top (
  input  logic                                                   clk,
  input  logic                                                   rst,
  input  logic                                                   read_en,
  input  rat_types_pkg::rat_rd_addr_t [rat_geom_pkg::NUM_RD-1:0]  rd_addr,
  input  rat_types_pkg::rat_wr_t      [rat_geom_pkg::NUM_WR-1:0]  wr,
  input  rat_types_pkg::rat_ret_t     [rat_geom_pkg::NUM_RET-1:0] ret,
  input  logic                                                   retire_all,
  output rat_types_pkg::rat_rd_rsp_t  [rat_geom_pkg::NUM_RD-1:0]  rd_rsp
);

  rat_types_pkg::rat_entry_t [rat_geom_pkg::NUM_ARCH-1:0] entries;

  genvar p;

  rat_table u_table (
    .clk        (clk),
    .rst        (rst),
    .read_en    (read_en),
    .wr         (wr),
    .ret        (ret),
    .retire_all (retire_all),
    .entries    (entries)
  );

  // all read ports see the same table state and rename slots
  generate
    for (p = 0; p < rat_geom_pkg::NUM_RD; p++)
    begin : g_rd
      rat_read_port u_rd (
        .clk     (clk),
        .rst     (rst),
        .read_en (read_en),
        .rd_addr (rd_addr[p]),
        .entries (entries),
        .wr      (wr),
        .rd_rsp  (rd_rsp[p])
      );
    end
  endgenerate

endmodule

//--- tb_rat.sv
// Register alias table testbench
// Drives rat_top with LFSR-based random renames, retirements and reads,
// tracks the table in a behavioral model and checks every read port
// each cycle

module tb_rat;

  timeunit 1ns;
  timeprecision 1ps;

  localparam logic [31:0] SEED            = 32'h33504ef7;
  localparam int          NUM_CYCLES      = 3000;
  localparam int          DIRECTED_CYCLES = 8;
  localparam longint      RST_TIMEOUT_NS  = 100;
  localparam longint      MAIN_TIMEOUT_NS = (NUM_CYCLES + 20) * 8 + 100;

  logic clk = 1'b0;
  logic rst;
  logic read_en;
  logic retire_all;
  rat_types_pkg::rat_rd_addr_t [rat_geom_pkg::NUM_RD-1:0]  rd_addr;
  rat_types_pkg::rat_wr_t      [rat_geom_pkg::NUM_WR-1:0]  wr;
  rat_types_pkg::rat_ret_t     [rat_geom_pkg::NUM_RET-1:0] ret;
  rat_types_pkg::rat_rd_rsp_t  [rat_geom_pkg::NUM_RD-1:0]  rd_rsp;

  // reference model state
  rat_types_pkg::rat_entry_t   m_ent  [rat_geom_pkg::NUM_ARCH];
  rat_types_pkg::reg_dom_e     m_pend [rat_geom_pkg::NUM_ARCH];
  rat_types_pkg::rat_rd_addr_t m_addr [rat_geom_pkg::NUM_RD];

  logic [31:0] lfsr;
  int          err_cnt;
  int          chk_cnt;
  int          rst_edges;
  int          cyc;
  logic        timed_out;

  rat_top u_dut (
    .clk        (clk),
    .rst        (rst),
    .read_en    (read_en),
    .rd_addr    (rd_addr),
    .wr         (wr),
    .ret        (ret),
    .retire_all (retire_all),
    .rd_rsp     (rd_rsp)
  );

  always #4 clk = ~clk;

  // right-shifting Galois form, taps 32 31 29 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    if (s[0])
      return (s >> 1) ^ 32'hD0000001;
    else
      return s >> 1;
  endfunction

  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++)
    begin
      v    = {v[30:0], lfsr[0]};
      lfsr = lfsr_step(lfsr);
    end
    return v;
  endfunction

  // half the picks land in r0..r3 so ports collide often
  function automatic logic [rat_geom_pkg::ARCH_W-1:0] pick_arch();
    logic [31:0] v;
    if (take_bits(1) != 0)
      v = take_bits(2);
    else
      v = take_bits(5);
    return v[rat_geom_pkg::ARCH_W-1:0];
  endfunction

  function automatic logic [rat_geom_pkg::FUN_W-1:0] fun_onehot(input int n);
    logic [rat_geom_pkg::FUN_W-1:0] f;
    f = '0;
    for (int k = 0; k < rat_geom_pkg::FUN_W; k++)
    begin
      if (k == n)
        f[k] = 1'b1;
    end
    return f;
  endfunction

  task automatic drive_inputs(input int c);
    logic [31:0] v;
    if (c < DIRECTED_CYCLES)
    begin
      // sweep all registers with arch reads and no updates
      read_en    = 1'b1;
      retire_all = 1'b0;
      wr         = '0;
      ret        = '0;
      for (int p = 0; p < rat_geom_pkg::NUM_RD; p++)
      begin
        rd_addr[p].dep     = 1'b0;
        rd_addr[p].reg_idx = 5'(c * rat_geom_pkg::NUM_RD + p);
      end
    end
    else
    begin
      read_en = (take_bits(2) != 0);
      for (int p = 0; p < rat_geom_pkg::NUM_RD; p++)
      begin
        rd_addr[p].dep = (take_bits(2) == 0);
        if (rd_addr[p].dep)
        begin
          // slots 3 and up are past the last rename port
          if (take_bits(1) != 0)
            v = take_bits(2);
          else
            v = take_bits(rat_geom_pkg::ARCH_W);
          rd_addr[p].reg_idx = v[rat_geom_pkg::ARCH_W-1:0];
        end
        else
          rd_addr[p].reg_idx = pick_arch();
      end
      for (int i = 0; i < rat_geom_pkg::NUM_WR; i++)
      begin
        wr[i].wen  = (take_bits(1) != 0);
        wr[i].arch = pick_arch();
        v          = take_bits(rat_geom_pkg::ROB_W);
        wr[i].tag  = v[rat_geom_pkg::ROB_W-1:0];
        wr[i].fun  = fun_onehot(int'(take_bits(4) % rat_geom_pkg::FUN_W));
        v          = take_bits(2);
        wr[i].dom  = rat_types_pkg::reg_dom_e'(v[1:0]);
      end
      for (int i = 0; i < rat_geom_pkg::NUM_RET; i++)
      begin
        ret[i].wen = (take_bits(5) < 13);
        if (take_bits(1) != 0)
        begin
          // reuse a tag the table holds so tag matches occur
          v          = take_bits(rat_geom_pkg::ARCH_W);
          ret[i].tag = m_ent[v[rat_geom_pkg::ARCH_W-1:0]].tag;
        end
        else
        begin
          v          = take_bits(rat_geom_pkg::ROB_W);
          ret[i].tag = v[rat_geom_pkg::ROB_W-1:0];
        end
        ret[i].arch = pick_arch();
        v           = take_bits(2);
        ret[i].dom  = rat_types_pkg::reg_dom_e'(v[1:0]);
      end
      retire_all = (take_bits(5) == 0);
    end
  endtask

  // apply one clock edge to the model with the inputs held at that edge
  task automatic model_edge();
    rat_types_pkg::rat_entry_t nxt;
    rat_types_pkg::rat_wr_t    w;
    logic                      ren;
    logic                      thit;
    if (rst)
    begin
      for (int n = 0; n < rat_geom_pkg::NUM_ARCH; n++)
      begin
        m_ent[n].tag     = '0;
        m_ent[n].retired = 1'b1;
        m_ent[n].fun     = rat_geom_pkg::FUN_RESET;
        m_ent[n].dom     = rat_types_pkg::DOM_INT;
        m_pend[n]        = rat_types_pkg::DOM_INT;
      end
      for (int p = 0; p < rat_geom_pkg::NUM_RD; p++)
        m_addr[p] = '0;
    end
    else
    begin
      for (int n = 0; n < rat_geom_pkg::NUM_ARCH; n++)
      begin
        nxt  = m_ent[n];
        w    = '0;
        ren  = 1'b0;
        thit = 1'b0;
        for (int i = 0; i < rat_geom_pkg::NUM_WR; i++)
        begin
          if (read_en && wr[i].wen && int'(wr[i].arch) == n)
          begin
            ren = 1'b1;
            w   = wr[i];
          end
        end
        for (int i = 0; i < rat_geom_pkg::NUM_RET; i++)
        begin
          if (ret[i].wen && ret[i].tag == m_ent[n].tag)
            thit = 1'b1;
        end
        if (ren)
        begin
          nxt.tag     = w.tag;
          nxt.fun     = w.fun;
          nxt.dom     = w.dom;
          nxt.retired = 1'b0;
        end
        else if (thit)
          nxt.retired = 1'b1;
        if (retire_all)
        begin
          nxt.retired = 1'b1;
          nxt.dom     = m_pend[n];
        end
        // pending is loaded after retire-all used the old value
        for (int i = 0; i < rat_geom_pkg::NUM_RET; i++)
        begin
          if (ret[i].wen && int'(ret[i].arch) == n)
            m_pend[n] = ret[i].dom;
        end
        m_ent[n] = nxt;
      end
      if (read_en)
      begin
        for (int p = 0; p < rat_geom_pkg::NUM_RD; p++)
          m_addr[p] = rd_addr[p];
      end
    end
  endtask

  function automatic rat_types_pkg::rat_rd_rsp_t expect_rsp(input int p);
    rat_types_pkg::rat_rd_rsp_t  r;
    rat_types_pkg::rat_rd_addr_t a;
    a = m_addr[p];
    r = '0;
    if (a.dep)
    begin
      r.is_dep = 1'b1;
      for (int i = 0; i < rat_geom_pkg::NUM_WR; i++)
      begin
        if (int'(a.reg_idx) == i)
        begin
          r.tag = wr[i].tag;
          r.fun = wr[i].fun;
          r.dom = wr[i].dom;
        end
      end
    end
    else
    begin
      r.tag     = m_ent[a.reg_idx].tag;
      r.retired = m_ent[a.reg_idx].retired;
      r.fun     = m_ent[a.reg_idx].fun;
      r.dom     = m_ent[a.reg_idx].dom;
    end
    return r;
  endfunction

  task automatic check_field(input string name, input int p, input logic [31:0] got,
                             input logic [31:0] want);
    chk_cnt++;
    assert (got == want)
    else
    begin
      err_cnt++;
      $display("ERR rd_rsp[%0d].%s got %h exp %h at %0t", p, name, got, want, $time);
    end
  endtask

  task automatic check_outputs();
    rat_types_pkg::rat_rd_rsp_t want;
    rat_types_pkg::rat_rd_rsp_t got;
    for (int p = 0; p < rat_geom_pkg::NUM_RD; p++)
    begin
      want = expect_rsp(p);
      got  = rd_rsp[p];
      check_field("tag", p, 32'(got.tag), 32'(want.tag));
      check_field("retired", p, 32'(got.retired), 32'(want.retired));
      check_field("is_dep", p, 32'(got.is_dep), 32'(want.is_dep));
      check_field("fun", p, 32'(got.fun), 32'(want.fun));
      check_field("dom", p, 32'(got.dom), 32'(want.dom));
    end
  endtask

  initial
  begin
    rst        = 1'b1;
    read_en    = 1'b0;
    retire_all = 1'b0;
    rd_addr    = '0;
    wr         = '0;
    ret        = '0;
    lfsr       = SEED;
    err_cnt    = 0;
    chk_cnt    = 0;
    rst_edges  = 0;
    timed_out  = 1'b0;

    while (rst_edges < 4 && !timed_out)
    begin
      @(posedge clk);
      model_edge();
      rst_edges++;
      if (rst_edges < 4 && $time > RST_TIMEOUT_NS)
      begin
        $display("timeout: reset sequence did not finish in time");
        timed_out = 1'b1;
      end
    end

    if (!timed_out)
    begin
      #1;
      rst = 1'b0;
      drive_inputs(0);
      #4;
      check_outputs();
    end

    cyc = 1;
    while (cyc < NUM_CYCLES && !timed_out)
    begin
      @(posedge clk);
      model_edge();
      #1;
      drive_inputs(cyc);
      #4;
      check_outputs();
      cyc++;
      if ($time > MAIN_TIMEOUT_NS)
      begin
        $display("timeout: main stimulus loop ran past its time limit");
        timed_out = 1'b1;
      end
    end

    $display("checks %0d, errors %0d", chk_cnt, err_cnt);
    if (err_cnt == 0 && !timed_out)
      $display("test passed");
    else
      $display("test failed");
    $finish;
  end

endmodule

//--- verilog.f
rat_geom_pkg.sv
rat_types_pkg.sv
rat_entry.sv
rat_table.sv
rat_read_port.sv
rat_top.sv
tb_rat.sv

//--- run.sh
#!/bin/sh
# build the RAT testbench with Verilator, run it and scan the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BIN=obj_dir/tb_rat_sim

verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module tb_rat -f verilog.f -o tb_rat_sim
if [ $? -ne 0 ]; then
  echo "verilator build did not succeed"
  exit 1
fi

./"$BIN" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "test failed" "$LOG"; then
  exit 1
fi

exit 0
